//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for five rising edges
    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_encoder_top.sv
`include "enc_settings.svh"

`default_nettype none

module tb_encoder_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SAMPLE_DIV  = 8;
    localparam int KEY_CNT_MAX = 40;
    localparam int POS_W       = `ENC_POS_W;
    // model timing
    localparam int PHASE_HOLD  = 4 * SAMPLE_DIV;
    localparam int KEY_HOLD    = 3 * KEY_CNT_MAX;
    localparam int SETTLE      = 6 * SAMPLE_DIV;
    // worst case lengths for the cycle budget
    localparam int CYCLE_LEN   = 4 * (PHASE_HOLD + 8);
    localparam int PRESS_LEN   = 2 * (KEY_HOLD + 8);
    localparam int BUS_LEN     = 24;
    localparam int BUS_OPS     = 40;
    // reference model event kinds
    localparam int EV_RIGHT    = 0;
    localparam int EV_LEFT     = 1;
    localparam int EV_PRESS    = 2;
    localparam int EV_CLEAR    = 3;

    logic            clk;
    logic            rstn;
    logic            a;
    logic            b;
    logic            key;
    logic            awvalid;
    logic            awready;
    logic [3:0]      awaddr;
    logic            wvalid;
    logic            wready;
    logic [31:0]     wdata;
    logic [3:0]      wstrb;
    logic            bvalid;
    logic            bready;
    axil_pkg::resp_t bresp;
    logic            arvalid;
    logic            arready;
    logic [3:0]      araddr;
    logic            rvalid;
    logic            rready;
    logic [31:0]     rdata;
    axil_pkg::resp_t rresp;

    integer seed = 32'h2c811456;

    // expected state
    logic [POS_W-1:0] exp_pos;
    logic [POS_W-1:0] exp_press;
    logic [POS_W-1:0] exp_steps;
    logic [1:0]       exp_ctrl;
    // what the pending bus response should be
    string            rd_name;
    logic [31:0]      rd_exp_data;
    axil_pkg::resp_t  rd_exp_resp;
    axil_pkg::resp_t  wr_exp_resp;

    int errors = 0;
    int checks = 0;
    int test_mark = 0;
    int cycles = 0;
    int timeout_limit = 0;
    int n_right;
    int n_left;

    clk_gen u_clk (
        .clk  (clk),
        .rstn (rstn)
    );

    encoder_top #(
        .SAMPLE_DIV  (SAMPLE_DIV),
        .KEY_CNT_MAX (KEY_CNT_MAX)
    ) uut (
        .clk     (clk),
        .rstn    (rstn),
        .a       (a),
        .b       (b),
        .key     (key),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    // reference model applying one event at a time
    function automatic void model_event(input int kind);
        case (kind)
            EV_RIGHT, EV_LEFT: begin
                // steps land only while counting is on
                if (exp_ctrl[0]) begin
                    if (kind == EV_RIGHT) begin
                        exp_pos = exp_pos + 1'b1;
                    end else begin
                        exp_pos = exp_pos - 1'b1;
                    end
                    exp_steps = exp_steps + 1'b1;
                end
            end
            EV_PRESS: begin
                exp_press = exp_press + 1'b1;
                if (exp_ctrl[1]) begin
                    exp_pos = POS_W'(`ENC_POS_INIT);
                end
            end
            default: begin
                exp_pos   = POS_W'(`ENC_POS_INIT);
                exp_steps = '0;
            end
        endcase
    endfunction

    // bit 2 of a CONTROL write acts as a clear and never sticks
    function automatic void model_write(input logic [3:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        if (addr == axil_pkg::reg_control && strb[0]) begin
            exp_ctrl = data[1:0];
            if (data[2]) begin
                model_event(EV_CLEAR);
            end
        end
    endfunction

    // position sign extended and counts zero extended
    function automatic logic [31:0] expected_read(input logic [3:0] addr);
        case (addr)
            axil_pkg::reg_position:    return 32'($signed(exp_pos));
            axil_pkg::reg_press_count: return 32'(exp_press);
            axil_pkg::reg_step_count:  return 32'(exp_steps);
            axil_pkg::reg_control:     return {30'd0, exp_ctrl};
            default:                   return 32'd0;
        endcase
    endfunction

    function automatic axil_pkg::resp_t expected_rresp(input logic [3:0] addr);
        case (addr)
            axil_pkg::reg_position, axil_pkg::reg_press_count,
            axil_pkg::reg_step_count, axil_pkg::reg_control: return axil_pkg::resp_okay;
            default: return axil_pkg::resp_slverr;
        endcase
    endfunction

    // only CONTROL takes writes
    function automatic axil_pkg::resp_t expected_wresp(input logic [3:0] addr);
        if (addr == axil_pkg::reg_control) begin
            return axil_pkg::resp_okay;
        end
        return axil_pkg::resp_slverr;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // compares every completed bus response
    always @(posedge clk) begin
        if (rvalid && rready) begin
            check_value($sformatf("%s read response", rd_name), 32'(rresp), 32'(rd_exp_resp));
            if (rd_exp_resp == axil_pkg::resp_okay) begin
                check_value($sformatf("%s read value", rd_name), rdata, rd_exp_data);
            end
        end
        if (bvalid && bready) begin
            check_value("write response", 32'(bresp), 32'(wr_exp_resp));
        end
    end

    // run limit from the motion, presses and bus traffic ahead
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            $display("run timed out, still busy after %0d cycles", timeout_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int hold);
        int delay;
        delay = hold + $unsigned($random(seed)) % 3;
        @(posedge clk);
        // expectation changes only once the previous response is compared
        wr_exp_resp = expected_wresp(addr);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // hold bready off for a while
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        while (!(bvalid && bready)) @(posedge clk);
        bready <= 1'b0;
        model_write(addr, data, strb);
    endtask

    task automatic axil_read(input logic [3:0] addr, input string name, input int hold);
        int delay;
        delay = hold + $unsigned($random(seed)) % 3;
        @(posedge clk);
        // expectation changes only once the previous response is compared
        rd_name     = name;
        rd_exp_data = expected_read(addr);
        rd_exp_resp = expected_rresp(addr);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        while (!(rvalid && rready)) @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic read_all(input int hold);
        axil_read(axil_pkg::reg_position, "position", hold);
        axil_read(axil_pkg::reg_press_count, "press_count", hold);
        axil_read(axil_pkg::reg_step_count, "step_count", hold);
        axil_read(axil_pkg::reg_control, "control", hold);
    endtask

    task automatic set_pin(input bit on_a, input logic level);
        if (on_a) begin
            a <= level;
        end else begin
            b <= level;
        end
    endtask

    // one phase edge preceded by a few one-cycle glitches
    // bounce stays shorter than one sample period
    task automatic pin_edge(input bit on_a, input logic level);
        int glitches;
        glitches = $unsigned($random(seed)) % 4;
        repeat (glitches) begin
            @(posedge clk);
            set_pin(on_a, level);
            @(posedge clk);
            set_pin(on_a, !level);
        end
        @(posedge clk);
        set_pin(on_a, level);
        repeat (PHASE_HOLD) @(posedge clk);
        // only A edges count
        // right when new A differs from B
        if (on_a) begin
            model_event((level != b) ? EV_RIGHT : EV_LEFT);
        end
    endtask

    // full quadrature cycles from and back to idle high
    task automatic rotate(input bit right, input int n);
        repeat (n) begin
            if (right) begin
                pin_edge(1'b1, 1'b0);
                pin_edge(1'b0, 1'b0);
                pin_edge(1'b1, 1'b1);
                pin_edge(1'b0, 1'b1);
            end else begin
                pin_edge(1'b0, 1'b0);
                pin_edge(1'b1, 1'b0);
                pin_edge(1'b0, 1'b1);
                pin_edge(1'b1, 1'b1);
            end
        end
        repeat (SETTLE) @(posedge clk);
    endtask

    // bouncy press, long hold, bouncy release
    task automatic press_key();
        int glitches;
        glitches = $unsigned($random(seed)) % 4;
        repeat (glitches) begin
            @(posedge clk);
            key <= 1'b0;
            @(posedge clk);
            key <= 1'b1;
        end
        @(posedge clk);
        key <= 1'b0;
        repeat (KEY_HOLD) @(posedge clk);
        model_event(EV_PRESS);
        glitches = $unsigned($random(seed)) % 4;
        repeat (glitches) begin
            @(posedge clk);
            key <= 1'b1;
            @(posedge clk);
            key <= 1'b0;
        end
        @(posedge clk);
        key <= 1'b1;
        repeat (KEY_HOLD) @(posedge clk);
    endtask

    // one line per test with the mismatches since the last one
    task automatic test_done(input int num, input string name);
        @(posedge clk);
        $display("test %0d %s: %0d mismatches", num, name, errors - test_mark);
        test_mark = errors;
    endtask

    initial begin
        a       = 1'b1;
        b       = 1'b1;
        key     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        exp_pos   = POS_W'(`ENC_POS_INIT);
        exp_press = '0;
        exp_steps = '0;
        exp_ctrl  = 2'b01;

        n_right = 1 + $unsigned($random(seed)) % 4;
        n_left  = n_right + 1 + $unsigned($random(seed)) % 4;
        timeout_limit = 2 * ((n_right + n_left + 4) * CYCLE_LEN + 2 * PRESS_LEN
                        + BUS_OPS * BUS_LEN + 8 * SETTLE) + 500;

        // handshake outputs quiet while in reset
        repeat (2) @(negedge clk);
        check_value("handshake outputs in reset",
                    32'({awready, wready, arready, bvalid, rvalid}), 32'd0);

        wait (rstn === 1'b1);

        read_all(0);
        test_done(1, "reset values");

        // more left than right so the position ends below zero
        rotate(1'b1, n_right);
        rotate(1'b0, n_left);
        axil_read(axil_pkg::reg_position, "position", 1);
        axil_read(axil_pkg::reg_step_count, "step_count", 1);
        test_done(2, $sformatf("rotation %0d right %0d left", n_right, n_left));

        axil_write(axil_pkg::reg_control, 32'h0, 4'hf, 0);
        rotate(1'b1, 2);
        axil_read(axil_pkg::reg_position, "position", 0);
        axil_read(axil_pkg::reg_step_count, "step_count", 0);
        axil_write(axil_pkg::reg_control, 32'h1, 4'hf, 0);
        test_done(3, "counting disabled");

        // clear-on-press first and a plain press after it
        axil_write(axil_pkg::reg_control, 32'h3, 4'hf, 0);
        press_key();
        axil_read(axil_pkg::reg_position, "position", 0);
        axil_read(axil_pkg::reg_press_count, "press_count", 0);
        axil_write(axil_pkg::reg_control, 32'h1, 4'hf, 0);
        rotate(1'b1, 1);
        press_key();
        axil_read(axil_pkg::reg_position, "position", 0);
        axil_read(axil_pkg::reg_press_count, "press_count", 0);
        test_done(4, "button press");

        // move further away from the start value before clearing
        rotate(1'b1, 1);
        axil_write(axil_pkg::reg_control, 32'h5, 4'hf, 1);
        axil_read(axil_pkg::reg_position, "position", 0);
        axil_read(axil_pkg::reg_step_count, "step_count", 0);
        axil_read(axil_pkg::reg_control, "control", 0);
        test_done(5, "clear");

        // slave errors under held-off ready
        axil_read(4'h6, "unmapped", 6);
        axil_write(axil_pkg::reg_position, 32'h0000_0abc, 4'hf, 6);
        read_all(5);
        test_done(6, "error responses");

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- encoder_top.f
+incdir+logic
logic/enc_pkg.sv
logic/axil_pkg.sv
logic/quad_decoder.sv
logic/key_filter.sv
logic/position_counter.sv
logic/axil_regs.sv
logic/encoder_top.sv
dv/clk_gen.sv
dv/tb_encoder_top.sv

//--- logic/axil_pkg.sv
`default_nettype none

package axil_pkg;

    // AXI4-Lite response codes, only the two used here
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // byte addresses of the four 32-bit registers
    // anything else decodes as unmapped
    typedef enum logic [3:0] {
        reg_position    = 4'h0,
        reg_press_count = 4'h4,
        reg_step_count  = 4'h8,
        reg_control     = 4'hc
    } reg_addr_t;

endpackage

`default_nettype wire

//--- logic/axil_regs.sv
`include "enc_settings.svh"

`default_nettype none

module axil_regs (
    input  wire                    clk,
    input  wire                    rstn,
    // write address and data
    input  wire                    awvalid,
    output logic                   awready,
    input  wire [3:0]              awaddr,
    input  wire                    wvalid,
    output logic                   wready,
    input  wire [31:0]             wdata,
    input  wire [3:0]              wstrb,
    // write response
    output logic                   bvalid,
    input  wire                    bready,
    output axil_pkg::resp_t        bresp,
    // read address and data
    input  wire                    arvalid,
    output logic                   arready,
    input  wire [3:0]              araddr,
    output logic                   rvalid,
    input  wire                    rready,
    output logic [31:0]            rdata,
    output axil_pkg::resp_t        rresp,
    // to and from the counters
    output logic                   count_en,
    output logic                   clear_on_press,
    output logic                   clear,
    input  wire [`ENC_POS_W-1:0]   position,
    input  wire [`ENC_POS_W-1:0]   press_count,
    input  wire [`ENC_POS_W-1:0]   step_count
);

    localparam int POS_W = `ENC_POS_W;
    localparam int CW    = enc_pkg::ctrl_width;

    logic                live;
    logic                wr_acc;
    logic                rd_acc;
    logic [CW-1:0]       ctrl_q;
    axil_pkg::reg_addr_t wr_addr;
    axil_pkg::reg_addr_t rd_addr;

    assign wr_addr = axil_pkg::reg_addr_t'(awaddr);
    assign rd_addr = axil_pkg::reg_addr_t'(araddr);

    // live rises one cycle after reset, keeps readies low until then
    // write takes address and data together, one at a time
    assign wr_acc  = live && awvalid && wvalid && !bvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;

    assign arready = live && !rvalid;
    assign rd_acc  = arvalid && arready;

    assign count_en       = ctrl_q[enc_pkg::ctrl_count_en];
    assign clear_on_press = ctrl_q[enc_pkg::ctrl_clear_on_press];
    assign clear          = ctrl_q[enc_pkg::ctrl_clear];

    // write side, CONTROL resets to counting enabled
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            live   <= 1'b0;
            bvalid <= 1'b0;
            ctrl_q <= '0;
            ctrl_q[enc_pkg::ctrl_count_en] <= 1'b1;
        end else begin
            live <= 1'b1;
            // clear bit drops by itself after one cycle
            ctrl_q[enc_pkg::ctrl_clear] <= 1'b0;
            if (wr_acc) begin
                bvalid <= 1'b1;
                // only byte 0 of CONTROL is writable
                if (wr_addr == axil_pkg::reg_control && wstrb[0]) begin
                    ctrl_q <= wdata[CW-1:0];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // counter registers are read only, writes there error out
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            if (wr_addr == axil_pkg::reg_control) begin
                bresp <= axil_pkg::resp_okay;
            end else begin
                bresp <= axil_pkg::resp_slverr;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rvalid <= 1'b0;
        end else if (rd_acc) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data captured at accept, held until rready
    // position is signed, the counts are not
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rresp <= axil_pkg::resp_okay;
            case (rd_addr)
                axil_pkg::reg_position: begin
                    rdata <= {{(32 - POS_W){position[POS_W-1]}}, position};
                end
                axil_pkg::reg_press_count: begin
                    rdata <= 32'(press_count);
                end
                axil_pkg::reg_step_count: begin
                    rdata <= 32'(step_count);
                end
                axil_pkg::reg_control: begin
                    rdata <= 32'(ctrl_q);
                end
                default: begin
                    rdata <= '0;
                    rresp <= axil_pkg::resp_slverr;
                end
            endcase
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rstn) rvalid && !rready |=> rvalid
    ) else $error("rvalid dropped before rready");

    a_rdata_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> $stable(rdata) && $stable(rresp)
    ) else $error("read data changed while stalled");

endmodule

`default_nettype wire

//--- logic/enc_pkg.sv
`default_nettype none

package enc_pkg;

    // direction of one decoded step
    typedef enum logic {
        dir_right = 1'b0,
        dir_left  = 1'b1
    } step_dir_t;

    // bit positions inside CONTROL
    // ctrl_clear reads back as a one-cycle pulse only
    typedef enum logic [1:0] {
        ctrl_count_en       = 2'd0,
        ctrl_clear_on_press = 2'd1,
        ctrl_clear          = 2'd2
    } ctrl_bit_t;

    // number of implemented CONTROL bits
    localparam int ctrl_width = 3;

endpackage

`default_nettype wire

//--- logic/enc_settings.svh
`ifndef ENC_SETTINGS_SVH
`define ENC_SETTINGS_SVH

// clock cycles between two phase sample ticks
// roughly the bounce time of a cheap mechanical encoder
`define ENC_SAMPLE_DIV 5000

// cycles the button must stay put before a press counts
`define ENC_KEY_CNT_MAX 99999

// width of position, press count and step count
`define ENC_POS_W 20

// position after reset, clear, or clear-on-press
`define ENC_POS_INIT 1

`endif

//--- logic/encoder_top.sv
`include "enc_settings.svh"

`default_nettype none

module encoder_top #(
    parameter int SAMPLE_DIV  = `ENC_SAMPLE_DIV,
    parameter int KEY_CNT_MAX = `ENC_KEY_CNT_MAX
) (
    input  wire              clk,
    input  wire              rstn,
    // encoder pins, idle high
    input  wire              a,
    input  wire              b,
    input  wire              key,
    // AXI4-Lite slave
    input  wire              awvalid,
    output logic             awready,
    input  wire [3:0]        awaddr,
    input  wire              wvalid,
    output logic             wready,
    input  wire [31:0]       wdata,
    input  wire [3:0]        wstrb,
    output logic             bvalid,
    input  wire              bready,
    output axil_pkg::resp_t  bresp,
    input  wire              arvalid,
    output logic             arready,
    input  wire [3:0]        araddr,
    output logic             rvalid,
    input  wire              rready,
    output logic [31:0]      rdata,
    output axil_pkg::resp_t  rresp
);

    // decoder and key filter to counters
    logic               step;
    enc_pkg::step_dir_t dir;
    logic               press;

    // control levels and clear pulse from the registers
    logic count_en;
    logic clear_on_press;
    logic clear;

    // counter values back to the registers
    logic [`ENC_POS_W-1:0] position;
    logic [`ENC_POS_W-1:0] press_count;
    logic [`ENC_POS_W-1:0] step_count;

    quad_decoder #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_decoder (
        .clk  (clk),
        .rstn (rstn),
        .a    (a),
        .b    (b),
        .step (step),
        .dir  (dir)
    );

    key_filter #(
        .CNT_MAX (KEY_CNT_MAX)
    ) u_key (
        .clk   (clk),
        .rstn  (rstn),
        .key   (key),
        .press (press)
    );

    position_counter u_count (
        .clk            (clk),
        .rstn           (rstn),
        .step           (step),
        .dir            (dir),
        .press          (press),
        .count_en       (count_en),
        .clear_on_press (clear_on_press),
        .clear          (clear),
        .position       (position),
        .press_count    (press_count),
        .step_count     (step_count)
    );

    axil_regs u_regs (
        .clk            (clk),
        .rstn           (rstn),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .count_en       (count_en),
        .clear_on_press (clear_on_press),
        .clear          (clear),
        .position       (position),
        .press_count    (press_count),
        .step_count     (step_count)
    );

endmodule

`default_nettype wire

//--- logic/key_filter.sv
`default_nettype none

module key_filter #(
    parameter int CNT_MAX = 99999
) (
    input  wire  clk,
    input  wire  rstn,
    input  wire  key,
    output logic press
);

    localparam int CNT_W = $clog2(CNT_MAX + 1);

    logic             key_s1;
    logic             key_s2;
    logic             key_d;
    logic             stable;
    logic [CNT_W-1:0] cnt;

    // synchronizer plus one more stage for change detect
    // idle level is high
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_s1 <= 1'b1;
            key_s2 <= 1'b1;
            key_d  <= 1'b1;
        end else begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_d  <= key_s2;
        end
    end

    assign stable = (key_s2 == key_d);

    // any change restarts the count
    // saturates so a long hold gives only one press
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (!stable) begin
            cnt <= '0;
        end else if (cnt != CNT_W'(CNT_MAX)) begin
            cnt <= cnt + 1'b1;
        end
    end

    // fire on the step into CNT_MAX, only for a low key
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            press <= 1'b0;
        end else begin
            press <= stable && !key_s2 && (cnt == CNT_W'(CNT_MAX - 1));
        end
    end

    a_press_pulse: assert property (
        @(posedge clk) disable iff (!rstn) press |=> !press
    ) else $error("press longer than one cycle");

endmodule

`default_nettype wire

//--- logic/position_counter.sv
`include "enc_settings.svh"

`default_nettype none

module position_counter (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      step,
    input  wire enc_pkg::step_dir_t  dir,
    input  wire                      press,
    input  wire                      count_en,
    input  wire                      clear_on_press,
    input  wire                      clear,
    output logic [`ENC_POS_W-1:0]    position,
    output logic [`ENC_POS_W-1:0]    press_count,
    output logic [`ENC_POS_W-1:0]    step_count
);

    localparam int                 POS_W    = `ENC_POS_W;
    localparam logic [POS_W-1:0]   POS_INIT = POS_W'(`ENC_POS_INIT);

    logic step_ok;

    // steps only count while enabled
    assign step_ok = step && count_en;

    // position, two's complement, wraps at POS_W
    // clear beats press-reset beats step
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            position <= POS_INIT;
        end else if (clear) begin
            position <= POS_INIT;
        end else if (press && clear_on_press) begin
            position <= POS_INIT;
        end else if (step_ok) begin
            if (dir == enc_pkg::dir_right) begin
                position <= position + 1'b1;
            end else begin
                position <= position - 1'b1;
            end
        end
    end

    // presses count even with counting disabled
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            press_count <= '0;
        end else if (press) begin
            press_count <= press_count + 1'b1;
        end
    end

    // total accepted steps, both directions
    // only a clear brings it back to zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step_count <= '0;
        end else if (clear) begin
            step_count <= '0;
        end else if (step_ok) begin
            step_count <= step_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/quad_decoder.sv
`default_nettype none

module quad_decoder #(
    parameter int SAMPLE_DIV = 5000
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               a,
    input  wire               b,
    output logic              step,
    output enc_pkg::step_dir_t dir
);

    localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // two samples per phase, taken only on tick
    logic a_s1;
    logic a_s2;
    logic b_s1;
    logic b_s2;

    // debounced levels and the delayed copy of A
    logic a_db;
    logic b_db;
    logic a_db_q;

    logic a_agree;
    logic b_agree;

    // slow sample tick, one cycle wide every SAMPLE_DIV cycles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == DIV_W'(SAMPLE_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // samplers start at the idle level so reset gives no edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            a_s1 <= 1'b1;
            a_s2 <= 1'b1;
            b_s1 <= 1'b1;
            b_s2 <= 1'b1;
        end else if (tick) begin
            a_s1 <= a;
            a_s2 <= a_s1;
            b_s1 <= b;
            b_s2 <= b_s1;
        end
    end

    // level accepted only when both samples match the live pin
    assign a_agree = (a_s1 == a) && (a_s2 == a);
    assign b_agree = (b_s1 == b) && (b_s2 == b);

    // otherwise hold the last accepted level
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            a_db   <= 1'b1;
            b_db   <= 1'b1;
            a_db_q <= 1'b1;
        end else begin
            if (a_agree) begin
                a_db <= a;
            end
            if (b_agree) begin
                b_db <= b;
            end
            a_db_q <= a_db;
        end
    end

    // either edge of debounced A is one step
    // A now differing from B means clockwise
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step <= 1'b0;
            dir  <= enc_pkg::dir_right;
        end else begin
            step <= a_db ^ a_db_q;
            dir  <= (a_db != b_db) ? enc_pkg::dir_right : enc_pkg::dir_left;
        end
    end

    // debounced A cannot toggle on back-to-back cycles
    a_step_single: assert property (
        @(posedge clk) disable iff (!rstn) step |=> !step
    ) else $error("step held high for two cycles");

endmodule

`default_nettype wire
